//--- rvPkg.sv
`default_nettype none

package rvPkg;

    // Major opcodes handled by the slice
    typedef enum logic [6:0] {
        opR      = 7'b0110011,
        opI      = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluAnd   = 4'd2,
        aluOr    = 4'd3,
        aluXor   = 4'd4,
        aluSll   = 4'd5,
        aluSrl   = 4'd6,
        aluSra   = 4'd7,
        aluSrai  = 4'd8,
        aluSlt   = 4'd9,
        aluSltu  = 4'd10,
        aluPassB = 4'd11
    } aluOpT;

    typedef enum logic [2:0] {
        immI     = 3'd0,
        immShamt = 3'd1,
        immS     = 3'd2,
        immB     = 3'd3,
        immU     = 3'd4,
        immJ     = 3'd5
    } immSrcT;

    // Write-back source
    typedef enum logic [1:0] {
        resAlu = 2'd0,
        resMem = 2'd1,
        resPc4 = 2'd2
    } resultSrcT;

    typedef struct packed {
        immSrcT    immSrc;
        logic      memWrite;
        logic      regWrite;
        aluOpT     aluOp;
        logic      aluSrcA;
        logic      aluSrcB;
        resultSrcT resultSrc;
        logic      branch;
        logic      jump;
    } ctrlT;

endpackage

`default_nettype wire

//--- rvIf.sv
`timescale 1ns/1ns
`default_nettype none

interface aluIf #(
    parameter int dataWidth = 32
);
    rvPkg::aluOpT         op;
    logic [dataWidth-1:0] srcA;
    logic [dataWidth-1:0] srcB;
    logic [dataWidth-1:0] result;

    modport ctl (output op, output srcA, output srcB, input result);
    modport unit (input op, input srcA, input srcB, output result);
endinterface

interface regIf #(
    parameter int dataWidth = 32,
    parameter int regCount  = 32
);
    localparam int addrWidth = $clog2(regCount);

    logic [addrWidth-1:0] raddr1;
    logic [addrWidth-1:0] raddr2;
    logic [dataWidth-1:0] rdata1;
    logic [dataWidth-1:0] rdata2;
    logic                 we;
    logic [addrWidth-1:0] waddr;
    logic [dataWidth-1:0] wdata;

    modport core (output raddr1, output raddr2, input rdata1, input rdata2,
                  output we, output waddr, output wdata);
    modport store (input raddr1, input raddr2, output rdata1, output rdata2,
                   input we, input waddr, input wdata);
endinterface

`default_nettype wire

//--- controlUnit.sv
`timescale 1ns/1ns
`default_nettype none

module controlUnit (
    input  logic [31:0] instr,
    input  logic        flush,
    input  logic        stall,
    output rvPkg::ctrlT ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    always_comb begin
        ctrl = '0;
        if (!flush) begin
            case (opcode)
                rvPkg::opR: begin
                    if (!stall)
                        ctrl.regWrite = 1'b1;
                    case (funct3)
                        3'b000: ctrl.aluOp = funct7b5 ? rvPkg::aluSub : rvPkg::aluAdd;
                        3'b001: ctrl.aluOp = rvPkg::aluSll;
                        3'b010: ctrl.aluOp = rvPkg::aluSlt;
                        3'b011: ctrl.aluOp = rvPkg::aluSltu;
                        3'b100: ctrl.aluOp = rvPkg::aluXor;
                        3'b101: ctrl.aluOp = funct7b5 ? rvPkg::aluSra : rvPkg::aluSrl;
                        3'b110: ctrl.aluOp = rvPkg::aluOr;
                        3'b111: ctrl.aluOp = rvPkg::aluAnd;
                    endcase
                end
                rvPkg::opI: begin
                    if (!stall)
                        ctrl.regWrite = 1'b1;
                    ctrl.aluSrcB = 1'b1;
                    case (funct3)
                        3'b000: ctrl.aluOp = rvPkg::aluAdd;
                        3'b001: begin
                            if (!funct7b5) begin
                                ctrl.aluOp  = rvPkg::aluSll;
                                ctrl.immSrc = rvPkg::immShamt;
                            end
                        end
                        3'b010: ctrl.aluOp = rvPkg::aluSlt;
                        3'b011: ctrl.aluOp = rvPkg::aluSltu;
                        3'b100: ctrl.aluOp = rvPkg::aluXor;
                        // SRLI or SRAI, shamt field only
                        3'b101: begin
                            ctrl.aluOp  = funct7b5 ? rvPkg::aluSrai : rvPkg::aluSrl;
                            ctrl.immSrc = rvPkg::immShamt;
                        end
                        3'b110: ctrl.aluOp = rvPkg::aluOr;
                        3'b111: ctrl.aluOp = rvPkg::aluAnd;
                    endcase
                end
                rvPkg::opLoad: begin
                    if (!stall)
                        ctrl.regWrite = 1'b1;
                    ctrl.aluSrcB   = 1'b1;
                    ctrl.resultSrc = rvPkg::resMem;
                end
                rvPkg::opStore: begin
                    if (!stall)
                        ctrl.memWrite = 1'b1;
                    ctrl.aluSrcB = 1'b1;
                    ctrl.immSrc  = rvPkg::immS;
                end
                rvPkg::opLui: begin
                    if (!stall)
                        ctrl.regWrite = 1'b1;
                    ctrl.aluOp   = rvPkg::aluPassB;
                    ctrl.aluSrcB = 1'b1;
                    ctrl.immSrc  = rvPkg::immU;
                end
                // PC plus upper immediate through the adder
                rvPkg::opAuipc: begin
                    if (!stall)
                        ctrl.regWrite = 1'b1;
                    ctrl.aluSrcA = 1'b1;
                    ctrl.aluSrcB = 1'b1;
                    ctrl.immSrc  = rvPkg::immU;
                end
                rvPkg::opJal: begin
                    if (!stall)
                        ctrl.regWrite = 1'b1;
                    ctrl.aluSrcA   = 1'b1;
                    ctrl.aluSrcB   = 1'b1;
                    ctrl.immSrc    = rvPkg::immJ;
                    ctrl.resultSrc = rvPkg::resPc4;
                    ctrl.jump      = 1'b1;
                end
                rvPkg::opJalr: begin
                    if (!stall) begin
                        ctrl.regWrite = 1'b1;
                        ctrl.jump     = 1'b1;
                    end
                    ctrl.aluSrcB   = 1'b1;
                    ctrl.resultSrc = rvPkg::resPc4;
                end
                rvPkg::opBranch: begin
                    if (!stall)
                        ctrl.branch = 1'b1;
                    ctrl.aluSrcA = 1'b1;
                    ctrl.aluSrcB = 1'b1;
                    ctrl.immSrc  = rvPkg::immB;
                end
                default: ;
            endcase
        end
    end

    // No opcode both stores and writes back
    always_comb begin
        assert final (!(ctrl.memWrite && ctrl.regWrite))
            else $error("controlUnit: memWrite and regWrite both high");
    end

endmodule

`default_nettype wire

//--- immExtend.sv
`timescale 1ns/1ns
`default_nettype none

module immExtend (
    input  logic [31:0]   instr,
    input  rvPkg::immSrcT immSrc,
    output logic [31:0]   imm
);

    always_comb begin
        case (immSrc)
            rvPkg::immI:
                imm = {{20{instr[31]}}, instr[31:20]};
            // Shift amount, zero extended
            rvPkg::immShamt:
                imm = {27'b0, instr[24:20]};
            rvPkg::immS:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rvPkg::immB:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            rvPkg::immU:
                imm = {instr[31:12], 12'b0};
            rvPkg::immJ:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu #(
    parameter int dataWidth = 32
) (
    aluIf.unit bus
);

    localparam int shiftBits = $clog2(dataWidth);

    logic [shiftBits-1:0] shamt;

    assign shamt = bus.srcB[shiftBits-1:0];

    always_comb begin
        case (bus.op)
            rvPkg::aluAdd:
                bus.result = bus.srcA + bus.srcB;
            rvPkg::aluSub:
                bus.result = bus.srcA - bus.srcB;
            rvPkg::aluAnd:
                bus.result = bus.srcA & bus.srcB;
            rvPkg::aluOr:
                bus.result = bus.srcA | bus.srcB;
            rvPkg::aluXor:
                bus.result = bus.srcA ^ bus.srcB;
            rvPkg::aluSll:
                bus.result = bus.srcA << shamt;
            rvPkg::aluSrl:
                bus.result = bus.srcA >> shamt;
            // Register and immediate forms shift the same way
            rvPkg::aluSra, rvPkg::aluSrai:
                bus.result = $signed(bus.srcA) >>> shamt;
            rvPkg::aluSlt:
                bus.result = dataWidth'($signed(bus.srcA) < $signed(bus.srcB));
            rvPkg::aluSltu:
                bus.result = dataWidth'(bus.srcA < bus.srcB);
            rvPkg::aluPassB:
                bus.result = bus.srcB;
            default:
                bus.result = '0;
        endcase
    end

    always_comb begin
        assert final (bus.op <= rvPkg::aluPassB)
            else $error("alu: undefined operation %0d", bus.op);
    end

endmodule

`default_nettype wire

//--- regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile #(
    parameter int dataWidth = 32,
    parameter int regCount  = 32
) (
    input logic clk,
    input logic rstN,
    regIf.store port
);

    logic [dataWidth-1:0] entries [regCount];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                entries[i] <= '0;
            end
        end else if (port.we && port.waddr != '0) begin
            entries[port.waddr] <= port.wdata;
        end
    end

    // x0 reads as zero
    assign port.rdata1 = (port.raddr1 == '0) ? '0 : entries[port.raddr1];
    assign port.rdata2 = (port.raddr2 == '0) ? '0 : entries[port.raddr2];

    // Entry 0 survives every write after reset
    assert property (@(posedge clk) disable iff (!rstN) entries[0] == '0)
        else $error("regFile: entry 0 changed");

endmodule

`default_nettype wire

//--- branchResolve.sv
`timescale 1ns/1ns
`default_nettype none

module branchResolve #(
    parameter int dataWidth = 32
) (
    input  logic [dataWidth-1:0] rs1,
    input  logic [dataWidth-1:0] rs2,
    input  logic [2:0]           funct3,
    input  logic                 branch,
    input  logic                 jump,
    output logic                 pcSrc
);

    logic taken;

    always_comb begin
        case (funct3)
            3'b000: taken = (rs1 == rs2);
            3'b001: taken = (rs1 != rs2);
            3'b100: taken = ($signed(rs1) < $signed(rs2));
            3'b101: taken = ($signed(rs1) >= $signed(rs2));
            3'b110: taken = (rs1 < rs2);
            3'b111: taken = (rs1 >= rs2);
            // Reserved codes never branch
            default: taken = 1'b0;
        endcase
    end

    assign pcSrc = jump || (branch && taken);

endmodule

`default_nettype wire

//--- rvExecCore.sv
`timescale 1ns/1ns
`default_nettype none

module rvExecCore #(
    parameter int dataWidth = 32,
    parameter int regCount  = 32
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [31:0]          instr,
    input  logic [dataWidth-1:0] pc,
    input  logic                 flush,
    input  logic                 stall,
    input  logic [dataWidth-1:0] readData,
    output logic [dataWidth-1:0] aluResult,
    output logic [dataWidth-1:0] writeData,
    output logic                 memWrite,
    output logic                 pcSrc,
    output logic [dataWidth-1:0] pcTarget
);

    localparam int addrWidth = $clog2(regCount);

    rvPkg::ctrlT          ctrl;
    logic [31:0]          imm;
    logic [dataWidth-1:0] immExt;
    logic [dataWidth-1:0] result;
    logic                 isJalr;

    aluIf #(.dataWidth(dataWidth)) aluBus ();
    regIf #(.dataWidth(dataWidth), .regCount(regCount)) regBus ();

    controlUnit controlUnit_inst (
        .instr (instr),
        .flush (flush),
        .stall (stall),
        .ctrl  (ctrl)
    );

    immExtend immExtend_inst (
        .instr  (instr),
        .immSrc (ctrl.immSrc),
        .imm    (imm)
    );

    alu #(.dataWidth(dataWidth)) alu_inst (
        .bus (aluBus.unit)
    );

    regFile #(.dataWidth(dataWidth), .regCount(regCount)) regFile_inst (
        .clk  (clk),
        .rstN (rstN),
        .port (regBus.store)
    );

    branchResolve #(.dataWidth(dataWidth)) branchResolve_inst (
        .rs1    (regBus.rdata1),
        .rs2    (regBus.rdata2),
        .funct3 (instr[14:12]),
        .branch (ctrl.branch),
        .jump   (ctrl.jump),
        .pcSrc  (pcSrc)
    );

    assign immExt = dataWidth'($signed(imm));

    assign regBus.raddr1 = instr[15 +: addrWidth];
    assign regBus.raddr2 = instr[20 +: addrWidth];

    assign aluBus.op   = ctrl.aluOp;
    assign aluBus.srcA = ctrl.aluSrcA ? pc : regBus.rdata1;
    assign aluBus.srcB = ctrl.aluSrcB ? immExt : regBus.rdata2;
    assign aluResult   = aluBus.result;

    // JALR links like JAL but adds to rs1
    assign isJalr   = (ctrl.resultSrc == rvPkg::resPc4) && !ctrl.aluSrcA;
    assign pcTarget = isJalr ? {aluBus.result[dataWidth-1:1], 1'b0} : aluBus.result;

    always_comb begin
        case (ctrl.resultSrc)
            rvPkg::resMem: result = readData;
            rvPkg::resPc4: result = pc + dataWidth'(4);
            default:       result = aluBus.result;
        endcase
    end

    assign regBus.we    = ctrl.regWrite;
    assign regBus.waddr = instr[7 +: addrWidth];
    assign regBus.wdata = result;

    assign writeData = regBus.rdata2;
    assign memWrite  = ctrl.memWrite;

endmodule

`default_nettype wire

//--- rvExecCoreTb.sv
`timescale 1ns/1ns
`default_nettype none

module rvExecCoreTb;

    localparam int clkPeriod = 100;
    // 144 instructions issued by the tests, plus the reset cycles
    localparam int plannedInstr = 149;

    logic        clk;
    logic        rstN;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        flush;
    logic        stall;
    logic [31:0] readData;
    logic [31:0] aluResult;
    logic [31:0] writeData;
    logic        memWrite;
    logic        pcSrc;
    logic [31:0] pcTarget;

    // Values applied with the next instruction
    logic [31:0] pcVal;
    logic [31:0] memVal;
    logic        flushVal;
    logic        stallVal;

    logic [31:0] a;
    logic [31:0] b;
    integer      seed;
    int          errors;
    int          issued;

    rvExecCore #(.dataWidth(32), .regCount(32)) rvExecCore_inst (
        .clk       (clk),
        .rstN      (rstN),
        .instr     (instr),
        .pc        (pc),
        .flush     (flush),
        .stall     (stall),
        .readData  (readData),
        .aluResult (aluResult),
        .writeData (writeData),
        .memWrite  (memWrite),
        .pcSrc     (pcSrc),
        .pcTarget  (pcTarget)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rvPkg::opR};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input rvPkg::opcodeT op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvPkg::opStore};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rvPkg::opBranch};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                         input rvPkg::opcodeT op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, rvPkg::opJal};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // Branch condition by funct3, reserved codes never taken
    function automatic logic takenRule(input logic [2:0] f3, input logic [31:0] x,
                                       input logic [31:0] y);
        case (f3)
            3'b000:  return x == y;
            3'b001:  return x != y;
            3'b100:  return $signed(x) < $signed(y);
            3'b101:  return $signed(x) >= $signed(y);
            3'b110:  return x < y;
            3'b111:  return x >= y;
            default: return 1'b0;
        endcase
    endfunction

    task automatic checkWord(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Apply one instruction at the rising edge, return mid-cycle
    task automatic issue(input logic [31:0] i);
        @(posedge clk);
        instr    <= i;
        pc       <= pcVal;
        readData <= memVal;
        flush    <= flushVal;
        stall    <= stallVal;
        issued++;
        @(negedge clk);
    endtask

    // Two reset cycles with a NOP held on the instruction port
    task automatic pulseReset();
        @(posedge clk);
        rstN  <= 1'b0;
        instr <= encI(12'd0, 5'd0, 3'd0, 5'd0, rvPkg::opI);
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
    endtask

    // ADDI x0, r, 0 shows the register on aluResult
    task automatic checkReg(input string name, input logic [4:0] r, input logic [31:0] exp);
        issue(encI(12'd0, r, 3'd0, 5'd0, rvPkg::opI));
        checkWord(name, exp, aluResult);
    endtask

    task automatic setReg(input logic [4:0] r, input logic [31:0] v);
        logic [19:0] upper;
        upper = v[31:12] + {19'b0, v[11]};
        issue(encU(upper, r, rvPkg::opLui));
        issue(encI(v[11:0], r, 3'd0, r, rvPkg::opI));
    endtask

    task automatic runR(input string name, input logic [6:0] f7, input logic [2:0] f3,
                        input logic [31:0] exp);
        issue(encR(f7, 5'd2, 5'd1, f3, 5'd3));
        checkWord(name, exp, aluResult);
        checkReg(name, 5'd3, exp);
    endtask

    task automatic runI(input string name, input logic [2:0] f3, input logic [11:0] imm,
                        input logic [31:0] exp);
        issue(encI(imm, 5'd1, f3, 5'd3, rvPkg::opI));
        checkWord(name, exp, aluResult);
        checkReg(name, 5'd3, exp);
    endtask

    task automatic testReset();
        // Nonzero contents first so the reset has something to clear
        for (int r = 1; r < 32; r += 7) begin
            setReg(5'(r), $random(seed) | 32'd1);
        end
        pulseReset();
        flushVal = 1'b1;
        issue(encS(12'h010, 5'd2, 5'd1));
        checkBit("reset store flushed", 1'b0, memWrite);
        issue(encJ(21'h100, 5'd1));
        checkBit("reset jal flushed", 1'b0, pcSrc);
        flushVal = 1'b0;
        for (int r = 1; r < 32; r += 7) begin
            checkReg("reset register", 5'(r), 32'd0);
        end
    endtask

    task automatic testAluOps();
        logic [11:0] imm;
        logic [19:0] upper;
        // Negative so arithmetic and logical right shifts differ
        a = $random(seed) | 32'h8000_0000;
        b = $random(seed);
        imm = 12'($random(seed));
        upper = 20'($random(seed));
        setReg(5'd1, a);
        setReg(5'd2, b);
        runR("ADD", 7'h00, 3'd0, a + b);
        runR("SUB", 7'h20, 3'd0, a - b);
        runR("SLL", 7'h00, 3'd1, a << b[4:0]);
        runR("SLT", 7'h00, 3'd2, {31'b0, $signed(a) < $signed(b)});
        runR("SLTU", 7'h00, 3'd3, {31'b0, a < b});
        runR("XOR", 7'h00, 3'd4, a ^ b);
        runR("SRL", 7'h00, 3'd5, a >> b[4:0]);
        runR("SRA", 7'h20, 3'd5, 32'($signed(a) >>> b[4:0]));
        runR("OR", 7'h00, 3'd6, a | b);
        runR("AND", 7'h00, 3'd7, a & b);
        runI("ADDI", 3'd0, imm, a + sext12(imm));
        runI("SLTI", 3'd2, imm, {31'b0, $signed(a) < $signed(sext12(imm))});
        runI("SLTIU", 3'd3, imm, {31'b0, a < sext12(imm)});
        runI("XORI", 3'd4, imm, a ^ sext12(imm));
        runI("ORI", 3'd6, imm, a | sext12(imm));
        runI("ANDI", 3'd7, imm, a & sext12(imm));
        runI("SLLI", 3'd1, {7'h00, b[4:0]}, a << b[4:0]);
        runI("SRLI", 3'd5, {7'h00, b[4:0]}, a >> b[4:0]);
        runI("SRAI", 3'd5, {7'h20, b[4:0]}, 32'($signed(a) >>> b[4:0]));
        issue(encU(upper, 5'd3, rvPkg::opLui));
        checkWord("LUI", {upper, 12'b0}, aluResult);
        checkReg("LUI", 5'd3, {upper, 12'b0});
        pcVal = $random(seed) & 32'hffff_fffc;
        issue(encU(upper, 5'd3, rvPkg::opAuipc));
        checkWord("AUIPC", pcVal + {upper, 12'b0}, aluResult);
        checkReg("AUIPC", 5'd3, pcVal + {upper, 12'b0});
        issue(encI(12'h005, 5'd1, 3'd0, 5'd0, rvPkg::opI));
        checkReg("x0 write", 5'd0, 32'd0);
    endtask

    task automatic testLoadStore();
        logic [11:0] imm;
        logic [31:0] addr;
        imm = 12'($random(seed));
        addr = a + sext12(imm);
        issue(encS(imm, 5'd2, 5'd1));
        checkBit("SW memWrite", 1'b1, memWrite);
        checkWord("SW address", addr, aluResult);
        checkWord("SW data", b, writeData);
        memVal = $random(seed);
        issue(encI(imm, 5'd1, 3'b010, 5'd4, rvPkg::opLoad));
        checkWord("LW address", addr, aluResult);
        checkBit("LW memWrite", 1'b0, memWrite);
        checkReg("LW", 5'd4, memVal);
    endtask

    task automatic testBranchJump();
        logic [31:0] lhs [5];
        logic [31:0] rhs [5];
        logic [12:0] off;
        logic [20:0] joff;
        logic [11:0] imm;
        // Equal, signed and unsigned order disagreeing, both agreeing
        lhs = '{32'h1234_5678, 32'hffff_fffb, 32'd7, 32'd3, 32'd9};
        rhs = '{32'h1234_5678, 32'd7, 32'hffff_fffb, 32'd9, 32'd3};
        for (int p = 0; p < 5; p++) begin
            setReg(5'd5, lhs[p]);
            setReg(5'd6, rhs[p]);
            for (int f = 0; f < 8; f++) begin
                off = 13'($random(seed)) & 13'h1ffe;
                pcVal = $random(seed) & 32'hffff_fffc;
                issue(encB(off, 5'd6, 5'd5, 3'(f)));
                checkBit("branch pcSrc", takenRule(3'(f), lhs[p], rhs[p]), pcSrc);
                checkWord("branch target", pcVal + {{19{off[12]}}, off}, pcTarget);
            end
        end
        joff = 21'($random(seed)) & 21'h1ffffe;
        pcVal = $random(seed) & 32'hffff_fffc;
        issue(encJ(joff, 5'd7));
        checkBit("JAL pcSrc", 1'b1, pcSrc);
        checkWord("JAL target", pcVal + {{11{joff[20]}}, joff}, pcTarget);
        checkReg("JAL link", 5'd7, pcVal + 32'd4);
        // Offset parity opposite to x1 so the sum is odd and the cleared bit 0 shows
        imm = 12'($random(seed));
        imm[0] = ~a[0];
        pcVal = $random(seed) & 32'hffff_fffc;
        issue(encI(imm, 5'd1, 3'd0, 5'd8, rvPkg::opJalr));
        checkBit("JALR pcSrc", 1'b1, pcSrc);
        checkWord("JALR target", (a + sext12(imm)) & 32'hffff_fffe, pcTarget);
        checkReg("JALR link", 5'd8, pcVal + 32'd4);
    endtask

    task automatic testFlushStall();
        // x5 is 9 and x6 is 3 here, so BNE would be taken
        flushVal = 1'b1;
        issue(encI(12'd123, 5'd0, 3'd0, 5'd1, rvPkg::opI));
        issue(encS(12'd8, 5'd2, 5'd1));
        checkBit("flush store", 1'b0, memWrite);
        issue(encB(13'd16, 5'd6, 5'd5, 3'b001));
        checkBit("flush branch", 1'b0, pcSrc);
        flushVal = 1'b0;
        checkReg("flush write", 5'd1, a);
        stallVal = 1'b1;
        issue(encI(12'd123, 5'd0, 3'd0, 5'd1, rvPkg::opI));
        issue(encS(12'd8, 5'd2, 5'd1));
        checkBit("stall store", 1'b0, memWrite);
        issue(encB(13'd16, 5'd6, 5'd5, 3'b001));
        checkBit("stall branch", 1'b0, pcSrc);
        issue(encJ(21'h40, 5'd10));
        checkBit("stall JAL", 1'b1, pcSrc);
        issue(encI(12'd0, 5'd1, 3'd0, 5'd11, rvPkg::opJalr));
        checkBit("stall JALR", 1'b0, pcSrc);
        stallVal = 1'b0;
        checkReg("stall write", 5'd1, a);
        checkReg("stall JAL link", 5'd10, 32'd0);
        checkReg("stall JALR link", 5'd11, 32'd0);
    endtask

    initial begin
        seed = 32'heefe;
        errors = 0;
        issued = 0;
        rstN = 1'b0;
        instr = 32'h0000_0013;
        pc = 32'd0;
        flush = 1'b0;
        stall = 1'b0;
        readData = 32'd0;
        pcVal = 32'd0;
        memVal = 32'd0;
        flushVal = 1'b0;
        stallVal = 1'b0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        testReset();
        testAluOps();
        testLoadStore();
        testBranchJump();
        testFlushStall();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((plannedInstr + 20) * clkPeriod);
        $display("Run timed out after %0d issued instructions", issued);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
rvPkg.sv
rvIf.sv
controlUnit.sv
immExtend.sv
alu.sv
regFile.sv
branchResolve.sv
rvExecCore.sv
rvExecCoreTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f build.f --top-module rvExecCoreTb -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep -q "All checks passed" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
